// File: verilog/uart_pkg.sv
package uart_pkg;

    // bus data word and serial payload
    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    // one access on the system bus, held for a single cycle
    typedef struct packed {
        logic  sel;       // access enable
        word_t addr;
        logic  write_en;  // 1 = write, 0 = read
        word_t wdata;
    } bus_req_t;

    // register offsets inside the four-address window
    localparam logic [1:0] OFS_TX_CMD  = 2'd0;
    localparam logic [1:0] OFS_TX_DATA = 2'd1;
    localparam logic [1:0] OFS_RX_STAT = 2'd2;
    localparam logic [1:0] OFS_RX_DATA = 2'd3;

    // transmit command: 1 = idle, writing 0 asks for a send
    localparam byte_t TX_CMD_IDLE = 8'h01;

    // receive status: 0 = nothing waiting, 1 = byte waiting
    localparam byte_t RX_STAT_EMPTY = 8'h00;

endpackage

// File: verilog/baud_tick_gen.sv
`timescale 1ns/10ps

module baud_tick_gen #(
    parameter int div = 25
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    // enough bits to hold div - 1, at least one
    localparam int cw = (div > 1) ? $clog2(div) : 1;

    logic [cw-1:0] cnt;

    // free-running, the tick is registered so it lands div cycles after reset
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (cnt == cw'(div - 1))
        begin
            cnt  <= '0;
            tick <= 1'b1;   // wrap
        end
        else
        begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

    // with a real divider the tick never repeats in back-to-back cycles
    a_tick_single: assert property (
        @(posedge clk) disable iff (!reset)
        (div > 1 && tick) |=> !tick
    ) else $error("baud tick high in two consecutive cycles");

endmodule

// File: verilog/uart_tx.sv
`timescale 1ns/10ps

module uart_tx (
    input  logic            clk,
    input  logic            reset,
    input  logic            tick,
    input  logic            tx_start,
    input  uart_pkg::byte_t tx_byte,
    output logic            tx,
    output logic            tx_done,
    output logic            busy
);

    typedef enum logic [1:0] {s_idle, s_start, s_data, s_stop} state_t;

    state_t          state;
    logic [2:0]      bit_cnt;
    uart_pkg::byte_t shreg;
    logic            load;

    // a frame begins on a tick once the line is free
    assign load = tick && tx_start && (state == s_idle || state == s_stop);
    assign busy = (state != s_idle);

    // byte latched with the start bit, then shifted out lsb first
    always_ff @(posedge clk)
    begin
        if (load)
            shreg <= tx_byte;
        else if (tick && (state == s_start || state == s_data))
            shreg <= shreg >> 1;
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state   <= s_idle;
            bit_cnt <= '0;
            tx      <= 1'b1;
            tx_done <= 1'b0;
        end
        else
        begin
            tx_done <= 1'b0;
            if (tick)
            begin
                case (state)
                    s_idle:
                    begin
                        if (tx_start)
                        begin
                            tx    <= 1'b0;      // start bit
                            state <= s_start;
                        end
                    end
                    s_start:
                    begin
                        tx      <= shreg[0];    // data bit 0
                        bit_cnt <= '0;
                        state   <= s_data;
                    end
                    s_data:
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            tx      <= 1'b1;    // stop bit
                            tx_done <= 1'b1;
                            state   <= s_stop;
                        end
                        else
                        begin
                            tx      <= shreg[0];
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    default:
                    begin
                        // end of stop bit, back to back frame if requested
                        if (tx_start)
                        begin
                            tx    <= 1'b0;
                            state <= s_start;
                        end
                        else
                            state <= s_idle;
                    end
                endcase
            end
        end
    end

    a_idle_high: assert property (
        @(posedge clk) disable iff (!reset)
        (state == s_idle) |-> tx
    ) else $error("tx line low while transmitter idle");

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/10ps

module uart_rx #(
    parameter int div = 25
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            rx,
    output uart_pkg::byte_t rx_byte,
    output logic            rx_valid
);

    localparam int cw = (div > 1) ? $clog2(div) : 1;

    typedef enum logic [1:0] {r_idle, r_start, r_data, r_stop} state_t;

    state_t          state;
    logic            rx_s1;
    logic            rx_s2;     // synchronized line
    logic [cw-1:0]   cnt;       // cycles to next sample point
    logic [2:0]      bit_cnt;
    uart_pkg::byte_t shreg;

    // data bits enter at the top, lsb ends up in bit 0
    always_ff @(posedge clk)
    begin
        if (state == r_data && cnt == '0)
            shreg <= {rx_s2, shreg[7:1]};
    end

    assign rx_byte = shreg;   // stable from the stop sample until the next frame

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_s1    <= 1'b1;
            rx_s2    <= 1'b1;
            state    <= r_idle;
            cnt      <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end
        else
        begin
            rx_s1    <= rx;
            rx_s2    <= rx_s1;
            rx_valid <= 1'b0;
            case (state)
                r_idle:
                begin
                    if (!rx_s2)
                    begin
                        cnt   <= cw'(div / 2);  // half a bit to the centre
                        state <= r_start;
                    end
                end
                r_start:
                begin
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    else if (!rx_s2)
                    begin
                        cnt     <= cw'(div - 1);
                        bit_cnt <= '0;
                        state   <= r_data;
                    end
                    else
                        state <= r_idle;        // glitch, not a start bit
                end
                r_data:
                begin
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    else
                    begin
                        cnt <= cw'(div - 1);
                        if (bit_cnt == 3'd7)
                            state <= r_stop;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default:
                begin
                    // stop bit level is not checked
                    if (cnt != '0)
                        cnt <= cnt - 1'b1;
                    else
                    begin
                        rx_valid <= 1'b1;
                        state    <= r_idle;
                    end
                end
            endcase
        end
    end

    a_valid_pulse: assert property (
        @(posedge clk) disable iff (!reset)
        rx_valid |=> !rx_valid
    ) else $error("rx_valid held longer than one cycle");

endmodule

// File: verilog/uart_regs.sv
`timescale 1ns/10ps

module uart_regs #(
    parameter logic [15:0] base_addr = 16'hFF08
) (
    input  logic               clk,
    input  logic               reset,
    input  uart_pkg::bus_req_t req,
    input  logic               busy,
    input  logic               tx_done,
    input  uart_pkg::byte_t    rx_byte,
    input  logic               rx_valid,
    output uart_pkg::word_t    rdata,
    output uart_pkg::byte_t    tx_byte,
    output logic               tx_start,
    output logic               irq
);

    uart_pkg::word_t delta;
    logic            hit;
    logic [1:0]      ofs;
    logic            wr;

    uart_pkg::byte_t tx_cmd;
    uart_pkg::byte_t tx_data;
    uart_pkg::byte_t rx_stat;
    uart_pkg::byte_t rx_data;
    logic            rx_valid_q;

    // window decode, addresses below base wrap to large values
    assign delta = req.addr - base_addr;
    assign hit   = req.sel && (delta[15:2] == '0);
    assign ofs   = delta[1:0];
    assign wr    = hit && req.write_en;

    assign tx_byte  = tx_data;
    assign tx_start = (tx_cmd == 8'h00);   // send requested

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            tx_cmd  <= uart_pkg::TX_CMD_IDLE;
            tx_data <= '0;
            rx_stat <= uart_pkg::RX_STAT_EMPTY;
            rx_data <= '0;
        end
        else
        begin
            if (tx_done)
                tx_cmd <= uart_pkg::TX_CMD_IDLE;   // frame handed off
            else if (wr && ofs == uart_pkg::OFS_TX_CMD)
                tx_cmd <= req.wdata[7:0];

            // data is frozen while a frame is on the line
            if (wr && ofs == uart_pkg::OFS_TX_DATA && !busy)
                tx_data <= req.wdata[7:0];

            if (rx_valid)
            begin
                rx_stat <= 8'h01;       // byte waiting
                rx_data <= rx_byte;     // overwrites an unread byte
            end
            else if (wr && ofs == uart_pkg::OFS_RX_STAT)
                rx_stat <= req.wdata[7:0];
        end
    end

    // zero padded read, nothing outside the window
    always_comb
    begin
        rdata = '0;
        if (hit)
        begin
            case (ofs)
                uart_pkg::OFS_TX_CMD:  rdata = {8'h00, tx_cmd};
                uart_pkg::OFS_TX_DATA: rdata = {8'h00, tx_data};
                uart_pkg::OFS_RX_STAT: rdata = {8'h00, rx_stat};
                default:               rdata = {8'h00, rx_data};
            endcase
        end
    end

    // interrupt on the rising edge of rx_valid
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rx_valid_q <= 1'b0;
            irq        <= 1'b0;
        end
        else
        begin
            rx_valid_q <= rx_valid;
            irq        <= rx_valid && !rx_valid_q;
        end
    end

    a_outside_zero: assert property (
        @(posedge clk) disable iff (!reset)
        (int'(req.addr) < int'(base_addr) || int'(req.addr) > int'(base_addr) + 3)
            |-> (rdata == '0)
    ) else $error("nonzero read outside the register window");

endmodule

// File: verilog/uart_periph.sv
`timescale 1ns/10ps

module uart_periph #(
    parameter int          clk_freq  = 25_000_000,
    parameter int          baud_rate = 1_000_000,
    parameter logic [15:0] base_addr = 16'hFF08
) (
    input  logic               clk,
    input  logic               reset,
    input  uart_pkg::bus_req_t req,
    input  logic               rx,
    output uart_pkg::word_t    rdata,
    output logic               tx,
    output logic               irq
);

    // bit period in clocks
    localparam int div = clk_freq / baud_rate;

    logic            tick;
    logic            tx_start;
    logic            tx_done;
    logic            busy;
    uart_pkg::byte_t tx_byte;
    uart_pkg::byte_t rx_byte;
    logic            rx_valid;

    baud_tick_gen #(.div(div)) i_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    uart_tx i_tx (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx       (tx),
        .tx_done  (tx_done),
        .busy     (busy)
    );

    // receiver runs from its own phase, not from the tick
    uart_rx #(.div(div)) i_rx (
        .clk      (clk),
        .reset    (reset),
        .rx       (rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_regs #(.base_addr(base_addr)) i_regs (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .busy     (busy),
        .tx_done  (tx_done),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rdata    (rdata),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .irq      (irq)
    );

endmodule

// File: sim/clk_gen.sv
`timescale 1ns/10ps

module clk_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // active low, released just after an edge
    initial
    begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2 reset = 1'b1;
    end

endmodule

// File: sim/uart_checker.sv
`timescale 1ns/10ps

module uart_checker #(
    parameter int bit_cycles = 25
) (
    input logic clk,
    input logic reset,
    input logic tx,
    input logic irq
);

    uart_pkg::byte_t exp_q[$];    // frames still to appear on tx
    int checks     = 0;
    int mismatches = 0;
    int failures   = 0;
    int frames     = 0;
    int pending    = 0;
    int irq_count  = 0;

    task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp)
        begin
            mismatches++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic fail(input string msg);
        failures++;
        $display("%s", msg);
    endtask

    task automatic expect_frame(input uart_pkg::byte_t b);
        exp_q.push_back(b);
        pending++;
    endtask

    task automatic report();
        $display("checks %0d, mismatches %0d, other failures %0d, frames %0d, irq pulses %0d",
                 checks, mismatches, failures, frames, irq_count);
    endtask

    // entered on the first negedge that shows the start bit
    task automatic decode_frame();
        uart_pkg::byte_t want;
        logic [9:0]      bits;      // start, data lsb first, stop
        logic            have;
        logic            held;
        int              i;
        int              c;
        have = (exp_q.size() > 0);
        want = have ? exp_q.pop_front() : 8'h00;
        held = 1'b1;
        if (!have)
            fail("start bit seen on tx while no frame was expected");
        for (i = 0; i < 10; i++)
        begin
            if (i > 0)
                @(negedge clk);
            bits[i] = tx;
            for (c = 1; c < bit_cycles; c++)
            begin
                @(negedge clk);
                if (tx !== bits[i])
                    held = 1'b0;    // level moved inside the bit
            end
        end
        if (!held)
            fail("a bit on tx did not last exactly one bit time");
        if (bits[9] !== 1'b1)
            fail("stop bit on tx was not high");
        if (have)
        begin
            compare("tx frame", {8'h00, bits[8:1]}, {8'h00, want});
            pending--;
        end
        frames++;
    endtask

    // negedge sampling keeps clear of the register updates
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (reset === 1'b1 && tx !== 1'b1)
                decode_frame();
        end
    end

    always @(negedge clk)
    begin
        if (reset === 1'b1 && irq !== 1'b0)
            irq_count++;
    end

endmodule

// File: sim/uart_tb.sv
`timescale 1ns/10ps

module uart_tb;

    localparam logic [15:0] base      = 16'hFF08;
    localparam int          bit_clks  = 25;
    localparam int          n_entries = 8;
    localparam int          limit     = n_entries * 12 * bit_clks + 200;

    localparam logic [1:0] op_send  = 2'd0;
    localparam logic [1:0] op_recv  = 2'd1;
    localparam logic [1:0] op_stray = 2'd2;

    typedef struct packed {
        logic [1:0] op;
        logic [7:0] data;
        logic [7:0] delay;  // receive only, start phase in cycles
    } entry_t;

    logic               clk;
    logic               reset;
    uart_pkg::bus_req_t req;
    logic               rx;
    uart_pkg::word_t    rdata;
    logic               tx;
    logic               irq;

    entry_t          stim[n_entries];
    integer          seed;
    int              cycles = 0;
    int              n_recv = 0;
    uart_pkg::byte_t exp_tx_data = 8'h00;
    uart_pkg::byte_t exp_rx_stat = 8'h00;
    uart_pkg::byte_t exp_rx_data = 8'h00;
    uart_pkg::word_t rd;

    clk_gen #(.period_ns(40), .reset_cycles(4)) i_clk (.clk(clk), .reset(reset));

    uart_periph #(
        .clk_freq  (25_000_000),
        .baud_rate (1_000_000),
        .base_addr (base)
    ) i_dut (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rx    (rx),
        .rdata (rdata),
        .tx    (tx),
        .irq   (irq)
    );

    uart_checker #(.bit_cycles(bit_clks)) i_chk (.clk(clk), .reset(reset), .tx(tx), .irq(irq));

    task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
        @(posedge clk);
        #2 req = '{sel: 1'b1, addr: addr, write_en: 1'b1, wdata: data};
        @(posedge clk);     // write lands here
        #2 req = '0;
    endtask

    task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
        @(posedge clk);
        #2 req = '{sel: 1'b1, addr: addr, write_en: 1'b0, wdata: 16'h0000};
        @(negedge clk);
        data = rdata;
        @(posedge clk);
        #2 req = '0;
    endtask

    task automatic read_check(input logic [15:0] addr, input logic [15:0] exp, input string name);
        logic [15:0] got;
        bus_read(addr, got);
        i_chk.compare(name, got, exp);
    endtask

    task automatic check_all_regs();
        read_check(base + 0, 16'h0001, "tx_cmd");
        read_check(base + 1, {8'h00, exp_tx_data}, "tx_data");
        read_check(base + 2, {8'h00, exp_rx_stat}, "rx_stat");
        read_check(base + 3, {8'h00, exp_rx_data}, "rx_data");
    endtask

    // 8N1 frame on rx, bits change just after the clock edge
    task automatic drive_frame(input uart_pkg::byte_t b, input int delay);
        logic [9:0] bits;
        int         i;
        bits = {1'b1, b, 1'b0};
        repeat (delay) @(posedge clk);
        for (i = 0; i < 10; i++)
        begin
            @(posedge clk);
            #2 rx = bits[i];
            repeat (bit_clks - 1) @(posedge clk);
        end
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= limit)
        begin
            $display("timeout: simulation did not finish");
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial
    begin
        seed = 32'h3353;
        req  = '0;
        rx   = 1'b1;    // idle line
        stim[0] = '{op_send,  8'hA5, 8'd0};
        stim[1] = '{op_recv,  8'h3C, 8'd0};
        stim[2] = '{op_stray, 8'h5A, 8'd0};
        stim[3] = '{op_send,  8'h01, 8'd0};
        stim[4] = '{op_recv,  8'hFF, 8'd0};
        stim[5] = '{op_send,  8'h80, 8'd0};
        stim[6] = '{op_recv,  8'h00, 8'd0};
        stim[7] = '{op_stray, 8'hC3, 8'd0};
        foreach (stim[k])
            if (stim[k].op == op_recv)
                stim[k].delay = 8'($unsigned($random(seed)) % bit_clks);

        @(posedge reset);
        check_all_regs();   // reset values

        foreach (stim[k])
        begin
            if (stim[k].op == op_send)
            begin
                bus_write(base + 1, {8'h00, stim[k].data});
                exp_tx_data = stim[k].data;
                i_chk.expect_frame(stim[k].data);
                bus_write(base + 0, 16'h0000);
                read_check(base + 0, 16'h0000, "tx_cmd");
                bus_read(base + 0, rd);
                while (rd != 16'h0001)
                    bus_read(base + 0, rd);     // back to 1 on the stop bit
                read_check(base + 1, {8'h00, exp_tx_data}, "tx_data");
                while (i_chk.pending != 0)
                    @(posedge clk);
            end
            else if (stim[k].op == op_recv)
            begin
                n_recv++;
                drive_frame(stim[k].data, stim[k].delay);
                while (i_chk.irq_count < n_recv)
                    @(posedge clk);
                i_chk.compare("irq count", 16'(i_chk.irq_count), 16'(n_recv));
                exp_rx_stat = 8'h01;
                exp_rx_data = stim[k].data;
                check_all_regs();
                bus_write(base + 2, 16'h0000);  // acknowledge
                exp_rx_stat = 8'h00;
                read_check(base + 2, 16'h0000, "rx_stat");
                read_check(base + 3, {8'h00, exp_rx_data}, "rx_data");
            end
            else
            begin
                bus_write(base + 4, {8'h00, stim[k].data});
                bus_write(base - 1, {8'h00, stim[k].data});
                read_check(base + 4, 16'h0000, "rdata above window");
                read_check(base - 1, 16'h0000, "rdata below window");
                check_all_regs();
            end
        end

        i_chk.compare("irq total", 16'(i_chk.irq_count), 16'(n_recv));
        i_chk.report();
        if (i_chk.mismatches == 0 && i_chk.failures == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: all.f
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_periph.sv
sim/clk_gen.sv
sim/uart_checker.sv
sim/uart_tb.sv

// File: Bender.yml
package:
  name: uart_periph

sources:
  - verilog/uart_pkg.sv
  - verilog/baud_tick_gen.sv
  - verilog/uart_tx.sv
  - verilog/uart_rx.sv
  - verilog/uart_regs.sv
  - verilog/uart_periph.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/uart_checker.sv
      - sim/uart_tb.sv
